// ==== hw/cache_defines.svh ====
// Cache geometry macros: address width, line size, line and way counts, field widths.
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Word address width.
`define CACHE_ADDR_W 16

// Words per line.
`define CACHE_LINE_WORDS 4

// Lines per way.
`define CACHE_LINES 8

// Number of ways.
`define CACHE_WAYS 2

// Field widths of a word address.
`define CACHE_OFS_W $clog2(`CACHE_LINE_WORDS)
`define CACHE_IDX_W $clog2(`CACHE_LINES)
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_IDX_W - `CACHE_OFS_W)
`define CACHE_WAY_W $clog2(`CACHE_WAYS)

`endif

// ==== hw/cache_pkg.sv ====
// Cache package with the word address union and its field types.
`include "cache_defines.svh"

package cache_pkg;

    // Tag, line index and word offset of a word address.
    typedef logic [`CACHE_TAG_W-1:0] cache_tag_t;
    typedef logic [`CACHE_IDX_W-1:0] cache_idx_t;
    typedef logic [`CACHE_OFS_W-1:0] cache_ofs_t;

    // Way number.
    typedef logic [`CACHE_WAY_W-1:0] way_sel_t;

    // Field view, tag in the top bits.
    typedef struct packed {
        cache_tag_t tag;
        cache_idx_t idx;
        cache_ofs_t ofs;
    } addr_fields_t;

    // Memory sees a flat word address, the cache sees the fields.
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] flat;
        addr_fields_t             f;
    } word_addr_u;

endpackage

// ==== hw/way_if.sv ====
// Way bus: common lookup and update commands to all ways, per-way status back.
`include "cache_defines.svh"

interface way_if (
    input logic clk,
    input logic rst_n
);
    import cache_pkg::*;

    // Lookup, shared by all ways. Also the line index for writes.
    cache_idx_t lookup_idx;
    cache_ofs_t lookup_ofs;
    cache_tag_t cmp_tag;

    // Tag, valid and dirty update.
    logic       tag_we;
    way_sel_t   tag_way;
    cache_tag_t tag_new;
    logic       valid_new;
    logic       dirty_new;

    // Data update.
    logic [3:0]  data_be;
    way_sel_t    data_way;
    cache_ofs_t  data_ofs;
    logic [31:0] data_wdata;

    // Per-way status, one lookup cycle behind the index.
    logic [`CACHE_WAYS-1:0] hit;
    logic [`CACHE_WAYS-1:0] valid;
    logic [`CACHE_WAYS-1:0] dirty;
    cache_tag_t             tag   [`CACHE_WAYS];
    logic [31:0]            rdata [`CACHE_WAYS];

    modport ctrl (
        output lookup_idx, lookup_ofs, cmp_tag,
        output tag_we, tag_way, tag_new, valid_new, dirty_new,
        output data_be, data_way, data_ofs, data_wdata,
        input  rdata
    );

    modport way (
        input  lookup_idx, lookup_ofs, cmp_tag,
        input  tag_we, tag_way, tag_new, valid_new, dirty_new,
        input  data_be, data_way, data_ofs, data_wdata,
        output hit, valid, dirty, tag, rdata
    );

    modport sel (
        input clk, rst_n,
        input hit, valid, dirty, tag, rdata
    );

endinterface

// ==== hw/cache_way.sv ====
// Cache way: tag, valid, dirty and data storage for one way, with hit compare.
`include "cache_defines.svh"

module cache_way #(
    parameter int way_num = 0
) (
    input logic clk,
    input logic rst_n,
    way_if.way  bus
);
    import cache_pkg::*;

    cache_tag_t              tag_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_mem;
    logic [`CACHE_LINES-1:0] dirty_mem;
    logic [31:0]             data_mem [`CACHE_LINES][`CACHE_LINE_WORDS];

    cache_tag_t  tag_q;
    logic        valid_q;
    logic        dirty_q;
    logic [31:0] rdata_q;

    logic tag_wr;
    logic data_wr;

    // An invalidating write clears the line in every way.
    assign tag_wr  = bus.tag_we && (bus.tag_way == way_sel_t'(way_num) || !bus.valid_new);
    assign data_wr = bus.data_way == way_sel_t'(way_num);

    // Tag side, write-first on the lookup register.
    always_ff @(posedge clk) begin
        if (tag_wr) begin
            tag_mem[bus.lookup_idx]   <= bus.tag_new;
            valid_mem[bus.lookup_idx] <= bus.valid_new;
            dirty_mem[bus.lookup_idx] <= bus.dirty_new;
            tag_q   <= bus.tag_new;
            valid_q <= bus.valid_new;
            dirty_q <= bus.dirty_new;
        end else begin
            tag_q   <= tag_mem[bus.lookup_idx];
            valid_q <= valid_mem[bus.lookup_idx];
            dirty_q <= dirty_mem[bus.lookup_idx];
        end
    end

    // Data side, per-byte writes.
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (data_wr && bus.data_be[b]) begin
                data_mem[bus.lookup_idx][bus.data_ofs][8*b +: 8] <= bus.data_wdata[8*b +: 8];
            end
        end
        rdata_q <= data_mem[bus.lookup_idx][bus.lookup_ofs];
    end

    assign bus.hit[way_num]   = valid_q && (tag_q == bus.cmp_tag);
    assign bus.valid[way_num] = valid_q;
    assign bus.dirty[way_num] = dirty_q;
    assign bus.tag[way_num]   = tag_q;
    assign bus.rdata[way_num] = rdata_q;

    // A line only becomes valid through a tag write.
    a_valid_needs_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !bus.tag_we |=> (valid_mem & ~$past(valid_mem)) == '0
    );

endmodule

// ==== hw/way_select.sv ====
// Way select: hit way encode, victim status and read data mux.
`include "cache_defines.svh"

module way_select (
    way_if.sel                    bus,
    input  cache_pkg::way_sel_t   victim,
    output logic                  hit,
    output cache_pkg::way_sel_t   hit_way,
    output logic                  victim_dirty,
    output cache_pkg::cache_tag_t victim_tag,
    output logic [31:0]           rdata
);
    import cache_pkg::*;

    // OR-encode, exact while at most one way hits.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (bus.hit[w]) begin
                hit_way = hit_way | way_sel_t'(w);
            end
        end
    end

    assign hit = |bus.hit;

    // A stale dirty flag on an invalid line is ignored.
    assign victim_dirty = bus.valid[victim] && bus.dirty[victim];
    assign victim_tag   = bus.tag[victim];

    assign rdata = bus.rdata[hit_way];

    // Two ways never hold the same tag at one index.
    a_onehot_hit: assert property (
        @(posedge bus.clk) disable iff (!bus.rst_n) $onehot0(bus.hit)
    );

endmodule

// ==== hw/cache_ctrl.sv ====
// Cache controller: access buffer, hit handling, write-back, line fill and reset sweep.
`include "cache_defines.svh"

module cache_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     re,
    input  logic [3:0]               we,
    input  cache_pkg::word_addr_u    addr,
    input  logic [31:0]              wdata,
    input  logic [31:0]              mem_rdata,
    input  logic                     mem_ready,
    input  logic                     hit,
    input  cache_pkg::way_sel_t      hit_way,
    input  logic                     victim_dirty,
    input  cache_pkg::cache_tag_t    victim_tag,
    output logic                     ready,
    output logic                     mem_re,
    output logic                     mem_we,
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    output logic [31:0]              mem_wdata,
    output cache_pkg::way_sel_t      victim,
    way_if.ctrl                      bus
);
    import cache_pkg::*;

    localparam logic [2:0] st_sweep    = 3'd0;
    localparam logic [2:0] st_idle     = 3'd1;
    localparam logic [2:0] st_lookup   = 3'd2;
    localparam logic [2:0] st_wb_prime = 3'd3;
    localparam logic [2:0] st_wb       = 3'd4;
    localparam logic [2:0] st_fill     = 3'd5;
    localparam logic [2:0] st_refill   = 3'd6;

    localparam cache_ofs_t last_ofs  = cache_ofs_t'(`CACHE_LINE_WORDS - 1);
    localparam cache_idx_t last_line = cache_idx_t'(`CACHE_LINES - 1);
    localparam way_sel_t   last_way  = way_sel_t'(`CACHE_WAYS - 1);

    logic [2:0] state;
    cache_ofs_t cnt;
    cache_idx_t sweep_idx;

    // Round-robin victim pointer per line.
    way_sel_t [`CACHE_LINES-1:0] rr;

    word_addr_u  ab_addr;
    logic [3:0]  ab_we;
    logic [31:0] ab_wdata;

    word_addr_u fill_a;
    word_addr_u wb_a;
    logic       req;

    assign req    = re || (we != 4'b0000);
    assign victim = rr[ab_addr.f.idx];

    // Access buffer.
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            ab_addr  <= addr;
            ab_we    <= re ? 4'b0000 : we;
            ab_wdata <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_sweep;
            cnt       <= '0;
            sweep_idx <= '0;
            rr        <= '0;
        end else begin
            case (state)
                st_sweep: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    if (sweep_idx == last_line) begin
                        state <= st_idle;
                    end
                end
                st_idle: begin
                    if (req) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    cnt <= '0;
                    if (hit) begin
                        state <= st_idle;
                    end else begin
                        state <= victim_dirty ? st_wb_prime : st_fill;
                    end
                end
                st_wb_prime: state <= st_wb;
                st_wb: begin
                    if (mem_ready) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == last_ofs) begin
                            state <= st_fill;
                        end
                    end
                end
                st_fill: begin
                    if (mem_ready) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == last_ofs) begin
                            rr[ab_addr.f.idx] <= (victim == last_way) ? '0 : victim + 1'b1;
                            state <= st_refill;
                        end
                    end
                end
                // One cycle for the new line to reach the lookup registers.
                default: state <= st_lookup;
            endcase
        end
    end

    // Line addresses for fill and write-back.
    always_comb begin
        fill_a.f.tag = ab_addr.f.tag;
        fill_a.f.idx = ab_addr.f.idx;
        fill_a.f.ofs = cnt;
        wb_a         = fill_a;
        wb_a.f.tag   = victim_tag;
    end

    assign mem_addr  = (state == st_wb) ? wb_a.flat : fill_a.flat;
    assign mem_wdata = bus.rdata[victim];

    always_comb begin
        bus.lookup_idx = ab_addr.f.idx;
        bus.lookup_ofs = ab_addr.f.ofs;
        bus.cmp_tag    = ab_addr.f.tag;
        bus.tag_we     = 1'b0;
        bus.tag_way    = hit_way;
        bus.tag_new    = ab_addr.f.tag;
        bus.valid_new  = 1'b1;
        bus.dirty_new  = 1'b0;
        bus.data_be    = 4'b0000;
        bus.data_way   = hit_way;
        bus.data_ofs   = ab_addr.f.ofs;
        bus.data_wdata = ab_wdata;
        ready          = 1'b0;
        mem_re         = 1'b0;
        mem_we         = 1'b0;
        case (state)
            st_sweep: begin
                bus.lookup_idx = sweep_idx;
                bus.tag_we     = 1'b1;
                bus.valid_new  = 1'b0;
            end
            st_idle: begin
                bus.lookup_idx = addr.f.idx;
                bus.lookup_ofs = addr.f.ofs;
                ready          = !req;
            end
            st_lookup: begin
                ready = hit;
                // Write hit merges bytes and marks the line dirty.
                if (hit && ab_we != 4'b0000) begin
                    bus.data_be   = ab_we;
                    bus.tag_we    = 1'b1;
                    bus.dirty_new = 1'b1;
                end
            end
            st_wb_prime: bus.lookup_ofs = cnt;
            st_wb: begin
                mem_we         = 1'b1;
                bus.lookup_ofs = mem_ready ? cnt + 1'b1 : cnt;
            end
            st_fill: begin
                mem_re = 1'b1;
                if (mem_ready) begin
                    bus.data_be    = 4'b1111;
                    bus.data_way   = victim;
                    bus.data_ofs   = cnt;
                    bus.data_wdata = mem_rdata;
                    bus.tag_we     = (cnt == last_ofs);
                    bus.tag_way    = victim;
                end
            end
            default: ;
        endcase
    end

    a_mem_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_re && mem_we)
    );

    // Memory request held steady until accepted.
    a_mem_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_re || mem_we) && !mem_ready |=> $stable({mem_re, mem_we, mem_addr})
    );

    // Write-back data held steady until accepted.
    a_wdata_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_we && !mem_ready |=> $stable(mem_wdata)
    );

endmodule

// ==== hw/cache_top.sv ====
// Cache top level: processor and memory ports around the controller, ways and selector.
`include "cache_defines.svh"

module cache_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     re,
    input  logic [3:0]               we,
    input  logic [`CACHE_ADDR_W-1:0] addr,
    input  logic [31:0]              wdata,
    input  logic [31:0]              mem_rdata,
    input  logic                     mem_ready,
    output logic                     ready,
    output logic [31:0]              rdata,
    output logic                     mem_re,
    output logic                     mem_we,
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    output logic [31:0]              mem_wdata
);
    import cache_pkg::*;

    way_if wbus (
        .clk   (clk),
        .rst_n (rst_n)
    );

    logic       hit;
    way_sel_t   hit_way;
    way_sel_t   victim;
    logic       victim_dirty;
    cache_tag_t victim_tag;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .re           (re),
        .we           (we),
        .addr         (addr),
        .wdata        (wdata),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .ready        (ready),
        .mem_re       (mem_re),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .victim       (victim),
        .bus          (wbus)
    );

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        cache_way #(
            .way_num (w)
        ) u_way (
            .clk   (clk),
            .rst_n (rst_n),
            .bus   (wbus)
        );
    end

    way_select u_sel (
        .bus          (wbus),
        .victim       (victim),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rdata        (rdata)
    );

endmodule

// ==== test/tb_cache.sv ====
// Cache testbench: accesses from a cases file against a memory model with random latency.
`include "cache_defines.svh"

module tb_cache;

    localparam int max_cases   = 64;
    localparam int half_period = 20;
    localparam int case_cycles = 200;

    localparam logic [`CACHE_ADDR_W-1:0] line_mask = `CACHE_ADDR_W'(`CACHE_LINE_WORDS - 1);
    localparam logic [`CACHE_ADDR_W-1:0] set_mask  =
        `CACHE_ADDR_W'(`CACHE_LINES * `CACHE_LINE_WORDS - 1);

    logic                     clk;
    logic                     rst_n;
    logic                     re;
    logic [3:0]               we;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [31:0]              wdata;
    logic [31:0]              mem_rdata;
    logic                     mem_ready;
    logic                     ready;
    logic [31:0]              rdata;
    logic                     mem_re;
    logic                     mem_we;
    logic [`CACHE_ADDR_W-1:0] mem_addr;
    logic [31:0]              mem_wdata;

    // Op, addr, be, wdata, rdata, memory reads, memory writes.
    logic [95:0] cases [max_cases];
    logic [31:0] mem_model [2**`CACHE_ADDR_W];
    logic [31:0] shadow [2**`CACHE_ADDR_W];

    // Memory traffic of the access in flight.
    logic [`CACHE_ADDR_W-1:0] rd_log [$];
    logic [`CACHE_ADDR_W-1:0] wr_log [$];
    logic                     wr_after_rd;

    integer seed = 32'h45da;
    int     n_cases;
    int     value_errors;
    int     other_errors;
    logic   loaded;

    cache_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .re        (re),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .ready     (ready),
        .rdata     (rdata),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    // Word memory, one transfer per mem_ready pulse after 0 to 3 wait cycles.
    initial begin : memory_model
        int                       delay;
        logic [`CACHE_ADDR_W-1:0] req_addr;
        @(negedge clk);
        forever begin
            if (rst_n && (mem_re || mem_we)) begin
                req_addr = mem_addr;
                delay    = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge clk);
                if (mem_addr !== req_addr) begin
                    $display("Memory address moved while waiting for mem_ready at %0t", $time);
                    other_errors++;
                end
                if (mem_re) begin
                    mem_rdata = mem_model[mem_addr];
                    rd_log.push_back(mem_addr);
                end else begin
                    mem_model[mem_addr] = mem_wdata;
                    wr_log.push_back(mem_addr);
                    if (rd_log.size() != 0) begin
                        wr_after_rd = 1'b1;
                    end
                end
                mem_ready = 1'b1;
                @(negedge clk);
                mem_ready = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

    // Ready low for the whole sweep, then idle.
    task automatic check_sweep();
        if (ready !== 1'b0 || mem_re !== 1'b0 || mem_we !== 1'b0) begin
            $display("Outputs not quiet at reset release: ready %b mem_re %b mem_we %b",
                     ready, mem_re, mem_we);
            other_errors++;
        end
        for (int i = 1; i <= `CACHE_LINES; i++) begin
            @(negedge clk);
            if (i < `CACHE_LINES && ready !== 1'b0) begin
                $display("ready went high during the reset sweep at %0t", $time);
                other_errors++;
            end
        end
        compare_word("ready after sweep", 32'(ready), 32'd1);
    endtask

    task automatic run_case(input logic [95:0] rec);
        logic [3:0]               op;
        logic [`CACHE_ADDR_W-1:0] a;
        logic [`CACHE_ADDR_W-1:0] base;
        logic [3:0]               be;
        logic [31:0]              wd;
        logic [31:0]              exp_rd;
        int                       exp_reads;
        int                       exp_writes;
        int                       cycles;
        {op, a, be, wd, exp_rd} = rec[95:8];
        exp_reads  = int'(rec[7:4]);
        exp_writes = int'(rec[3:0]);
        base       = a & ~line_mask;
        rd_log.delete();
        wr_log.delete();
        wr_after_rd = 1'b0;
        addr  = a;
        wdata = wd;
        re    = (op == 4'h0);
        we    = (op == 4'h0) ? 4'b0000 : be;
        if (op != 4'h0) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    shadow[a][8*b +: 8] = wd[8*b +: 8];
                end
            end
        end
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ready !== 1'b1);
        if (op == 4'h0) begin
            compare_word("rdata", rdata, exp_rd);
        end
        // A hit completes one cycle after the request is sampled.
        if (exp_reads == 0 && exp_writes == 0) begin
            compare_word("hit latency", 32'(cycles), 32'd1);
        end
        compare_word("memory reads", 32'(rd_log.size()), 32'(exp_reads));
        compare_word("memory writes", 32'(wr_log.size()), 32'(exp_writes));
        for (int i = 0; i < rd_log.size(); i++) begin
            compare_word("fill address", 32'(rd_log[i]), 32'(base + `CACHE_ADDR_W'(i)));
        end
        for (int i = 0; i < wr_log.size(); i++) begin
            compare_word("write-back line and offset", 32'(wr_log[i] & set_mask),
                         32'((base + `CACHE_ADDR_W'(i)) & set_mask));
            compare_word($sformatf("mem[%h]", wr_log[i]), mem_model[wr_log[i]],
                         shadow[wr_log[i]]);
        end
        if (wr_after_rd) begin
            $display("Write-back word came after a fill read at %0t", $time);
            other_errors++;
        end
        @(posedge clk);
        @(negedge clk);
        re = 1'b0;
        we = 4'b0000;
    endtask

    initial begin : watchdog
        wait (loaded);
        #((n_cases * case_cycles + `CACHE_LINES + 8) * 2 * half_period);
        $display("Timeout: the cases did not finish in %0d cycles each", case_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        rst_n        = 1'b0;
        re           = 1'b0;
        we           = 4'b0000;
        addr         = '0;
        wdata        = '0;
        mem_rdata    = '0;
        mem_ready    = 1'b0;
        loaded       = 1'b0;
        n_cases      = 0;
        value_errors = 0;
        other_errors = 0;
        for (int a = 0; a < 2**`CACHE_ADDR_W; a++) begin
            mem_model[a] = {16'hC0DE, `CACHE_ADDR_W'(a)};
            shadow[a]    = {16'hC0DE, `CACHE_ADDR_W'(a)};
        end
        // Op F marks the end of the list.
        for (int i = 0; i < max_cases; i++) begin
            cases[i] = '1;
        end
        $readmemh("test/cache_cases.txt", cases);
        while (n_cases < max_cases && cases[n_cases][95:92] != 4'hF) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("No cases were read from test/cache_cases.txt");
            other_errors++;
        end
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_sweep();
        for (int i = 0; i < n_cases; i++) begin
            run_case(cases[i]);
        end
        $display("%0d cases run, %0d value errors, %0d other errors",
                 n_cases, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== test/cache_cases.txt ====
// Columns op_addr_be_wdata_rdata_reads_writes; op 0 is a read, 1 a write; word addresses.
// reads and writes count the memory words the access moves; rdata is checked on reads.
0_0009_0_00000000_C0DE0009_4_0
0_0009_0_00000000_C0DE0009_0_0
0_000B_0_00000000_C0DE000B_0_0
1_000A_3_12345678_00000000_0_0
0_000A_0_00000000_C0DE5678_0_0
1_0008_8_AB000000_00000000_0_0
0_0008_0_00000000_ABDE0008_0_0
0_0029_0_00000000_C0DE0029_4_0
0_0009_0_00000000_C0DE0009_0_0
0_0049_0_00000000_C0DE0049_4_4
0_002A_0_00000000_C0DE002A_0_0
0_000A_0_00000000_C0DE5678_4_0
0_0008_0_00000000_ABDE0008_0_0
0_004B_0_00000000_C0DE004B_0_0
1_0031_F_DEADBEEF_00000000_4_0
0_0031_0_00000000_DEADBEEF_0_0
1_0032_4_00770000_00000000_0_0
0_0032_0_00000000_C0770032_0_0
0_0051_0_00000000_C0DE0051_4_0
0_0071_0_00000000_C0DE0071_4_4
0_0033_0_00000000_C0DE0033_4_0
0_0031_0_00000000_DEADBEEF_0_0
0_FFFF_0_00000000_C0DEFFFF_4_0
0_FFFC_0_00000000_C0DEFFFC_0_0

// ==== list.f ====
+incdir+hw
hw/cache_pkg.sv
hw/way_if.sv
hw/cache_way.sv
hw/way_select.sv
hw/cache_ctrl.sv
hw/cache_top.sv
test/tb_cache.sv

// ==== Makefile ====
# Verilator build and run of the cache testbench.

VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ALL CHECKS PASSED

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hw/*.sv hw/*.svh test/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
